/* source/ifu_pkg.sv */
package ifu_pkg;

  // **************************************************
  // Widths and reset address
  // **************************************************
  localparam int XLEN = 32;
  localparam logic [XLEN-1:0] PC_INIT = 32'h8000_0000;

  // **************************************************
  // L1 instruction cache geometry
  // **************************************************
  localparam int L1I_SETS = 4;
  localparam int L1I_WORDS = 2;
  localparam int IDX_W = 2;
  localparam int OFS_W = 1;
  // Two low bits select the byte inside a word
  localparam int TAG_W = XLEN - IDX_W - OFS_W - 2;

  // **************************************************
  // RV32I opcodes seen by fetch
  // **************************************************
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JALR = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;

  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  typedef enum logic [1:0] {
    FETCH  = 2'd0,
    HAZARD = 2'd1,
    FLUSH  = 2'd2
  } fetch_state_t;

endpackage

/* source/ifu_refill_counter.sv */
`timescale 1ns/1ps

module ifu_refill_counter (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start_i,
  input  logic                      ack_i,
  output logic [ifu_pkg::OFS_W-1:0] beat_idx_o,
  output logic                      busy_o,
  output logic                      last_beat_o
);

  logic [ifu_pkg::OFS_W-1:0] beat_q;
  logic                      busy_q;

  assign beat_idx_o = beat_q;
  assign busy_o = busy_q;
  assign last_beat_o = busy_q && (int'(beat_q) == ifu_pkg::L1I_WORDS - 1);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      beat_q <= '0;
    end else if (!busy_q) begin
      if (start_i) begin
        busy_q <= 1'b1;
        beat_q <= '0;
      end
    end else if (ack_i) begin
      // The line is complete once the last word is acknowledged
      if (last_beat_o) begin
        busy_q <= 1'b0;
      end
      beat_q <= beat_q + 1'b1;
    end
  end

endmodule

/* source/ifu_l1i_cache.sv */
`timescale 1ns/1ps

module ifu_l1i_cache (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [ifu_pkg::XLEN-1:0] pc_i,
  input  logic                     flush_i,
  input  logic [ifu_pkg::XLEN-1:0] rdata_i,
  input  logic                     rvalid_i,
  output logic                     hit_o,
  output logic [ifu_pkg::XLEN-1:0] inst_o,
  output logic                     idle_o,
  output logic [ifu_pkg::XLEN-1:0] araddr_o,
  output logic                     arvalid_o,
  output logic                     required_o
);

  logic [ifu_pkg::TAG_W-1:0]   tag_q [ifu_pkg::L1I_SETS];
  logic [ifu_pkg::XLEN-1:0]    data_q [ifu_pkg::L1I_SETS][ifu_pkg::L1I_WORDS];
  logic [ifu_pkg::L1I_SETS-1:0] valid_q;

  // Line address of the refill in progress
  logic [ifu_pkg::XLEN-1:ifu_pkg::OFS_W+2] line_q;
  logic                                    gap_q;

  logic [ifu_pkg::TAG_W-1:0] pc_tag;
  logic [ifu_pkg::IDX_W-1:0] pc_idx;
  logic [ifu_pkg::OFS_W-1:0] pc_ofs;
  logic [ifu_pkg::TAG_W-1:0] line_tag;
  logic [ifu_pkg::IDX_W-1:0] line_idx;

  logic                      beat_start;
  logic                      beat_ack;
  logic [ifu_pkg::OFS_W-1:0] beat_idx;
  logic                      busy;
  logic                      last_beat;

  assign pc_tag = pc_i[ifu_pkg::XLEN-1 -: ifu_pkg::TAG_W];
  assign pc_idx = pc_i[ifu_pkg::OFS_W+2 +: ifu_pkg::IDX_W];
  assign pc_ofs = pc_i[2 +: ifu_pkg::OFS_W];
  assign line_tag = line_q[ifu_pkg::XLEN-1 -: ifu_pkg::TAG_W];
  assign line_idx = line_q[ifu_pkg::OFS_W+2 +: ifu_pkg::IDX_W];

  // **************************************************
  // Lookup
  // **************************************************
  assign hit_o = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign inst_o = data_q[pc_idx][pc_ofs];
  assign idle_o = !busy;

  // **************************************************
  // Refill over the read bus
  // **************************************************
  assign beat_start = !hit_o && !busy;
  // The request drops for one cycle between the words of a line
  assign arvalid_o = busy && !gap_q;
  assign beat_ack = arvalid_o && rvalid_i;
  assign required_o = busy;
  assign araddr_o = {line_q, beat_idx, 2'b00};

  ifu_refill_counter i_refill_counter (
    .clk        (clk),
    .rst        (rst),
    .start_i    (beat_start),
    .ack_i      (beat_ack),
    .beat_idx_o (beat_idx),
    .busy_o     (busy),
    .last_beat_o(last_beat)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      gap_q <= 1'b0;
    end else begin
      gap_q <= beat_ack && !last_beat;
      if (flush_i) begin
        valid_q <= '0;
      end else if (beat_start) begin
        valid_q[pc_idx] <= 1'b0;
      end else if (beat_ack && last_beat) begin
        valid_q[line_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_start) begin
      line_q <= pc_i[ifu_pkg::XLEN-1:ifu_pkg::OFS_W+2];
    end
    if (beat_ack) begin
      data_q[line_idx][beat_idx] <= rdata_i;
      tag_q[line_idx] <= line_tag;
    end
  end

endmodule

/* source/ifu_spec_tracker.sv */
`timescale 1ns/1ps

module ifu_spec_tracker (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     prev_valid_i,
  input  logic                     pc_change_i,
  input  logic [ifu_pkg::XLEN-1:0] npc_i,
  input  logic                     pc_retire_i,
  input  logic [ifu_pkg::XLEN-1:0] pc_i,
  input  logic                     spec_start_i,
  input  logic [ifu_pkg::XLEN-1:0] spec_target_i,
  input  logic [ifu_pkg::XLEN-1:0] fallthrough_pc_i,
  input  logic                     spec_active_i,
  output logic                     btb_valid_o,
  output logic [ifu_pkg::XLEN-1:0] btb_target_o,
  output logic                     spec_good_o,
  output logic                     spec_bad_o,
  output logic [ifu_pkg::XLEN-1:0] redirect_pc_o,
  output logic                     speculation_o,
  output logic                     good_speculation_o,
  output logic                     bad_speculation_o
);

  logic                     btb_valid_q;
  logic [ifu_pkg::XLEN-1:0] btb_target_q;
  logic [ifu_pkg::XLEN-1:0] target_q;
  logic [ifu_pkg::XLEN-1:0] fallthrough_q;
  logic [ifu_pkg::XLEN-1:0] redirect_q;
  logic                     bad_q;
  logic                     guess_open;
  logic                     resolve;
  logic                     match;

  // A guess stays open until it is resolved, the flush that follows a bad one excluded
  assign guess_open = spec_active_i && !bad_q;
  assign resolve = guess_open && prev_valid_i && (pc_change_i || pc_retire_i);
  assign match = pc_change_i ? (npc_i == target_q) : (pc_i + 32'd4 == target_q);

  assign spec_good_o = resolve && match;
  assign spec_bad_o = resolve && !match;

  assign btb_valid_o = btb_valid_q;
  assign btb_target_o = btb_target_q;
  assign redirect_pc_o = redirect_q;

  assign speculation_o = guess_open;
  assign good_speculation_o = spec_good_o;
  assign bad_speculation_o = spec_bad_o || (bad_q && spec_active_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      btb_valid_q <= 1'b0;
      bad_q <= 1'b0;
    end else begin
      if (prev_valid_i && pc_change_i) begin
        btb_valid_q <= 1'b1;
      end
      bad_q <= spec_bad_o || (bad_q && spec_active_i);
    end
  end

  always_ff @(posedge clk) begin
    if (prev_valid_i && pc_change_i) begin
      btb_target_q <= npc_i;
    end
    if (spec_start_i) begin
      target_q <= spec_target_i;
      fallthrough_q <= fallthrough_pc_i;
    end
    if (spec_bad_o) begin
      redirect_q <= pc_change_i ? npc_i : fallthrough_q;
    end
  end

endmodule

/* source/ifu_fetch_fsm.sv */
`timescale 1ns/1ps

module ifu_fetch_fsm (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     hit_i,
  input  logic [ifu_pkg::XLEN-1:0] inst_i,
  input  logic                     cache_idle_i,
  input  logic                     next_ready_i,
  input  logic                     prev_valid_i,
  input  logic                     pc_change_i,
  input  logic [ifu_pkg::XLEN-1:0] npc_i,
  input  logic                     pc_retire_i,
  input  logic [ifu_pkg::XLEN-1:0] pc_i,
  input  logic                     btb_valid_i,
  input  logic [ifu_pkg::XLEN-1:0] btb_target_i,
  input  logic                     spec_good_i,
  input  logic                     spec_bad_i,
  input  logic [ifu_pkg::XLEN-1:0] redirect_pc_i,
  output logic [ifu_pkg::XLEN-1:0] fetch_pc_o,
  output logic                     valid_o,
  output logic                     flush_req_o,
  output logic                     spec_start_o,
  output logic [ifu_pkg::XLEN-1:0] spec_target_o,
  output logic [ifu_pkg::XLEN-1:0] fallthrough_pc_o,
  output logic                     spec_active_o
);

  ifu_pkg::fetch_state_t    state_q;
  logic [ifu_pkg::XLEN-1:0] pc_q;
  logic                     spec_q;

  logic [6:0] opcode;
  logic       is_branch;
  logic       is_load;
  logic       is_store;
  logic       is_fence;
  logic       accept;
  logic       resolved;

  assign opcode = inst_i[6:0];
  assign is_branch = (opcode == ifu_pkg::OP_JAL) || (opcode == ifu_pkg::OP_JALR) ||
                     (opcode == ifu_pkg::OP_BRANCH) || (opcode == ifu_pkg::OP_SYSTEM);
  assign is_load = (opcode == ifu_pkg::OP_LOAD);
  assign is_store = (opcode == ifu_pkg::OP_STORE);
  assign is_fence = (inst_i == ifu_pkg::INST_FENCE_I);

  // Memory accesses wait until the open guess is resolved
  assign valid_o = hit_i && (state_q == ifu_pkg::FETCH) && !spec_bad_i &&
                   !(spec_q && (is_load || is_store));
  assign accept = valid_o && next_ready_i;
  assign resolved = prev_valid_i && (pc_change_i || pc_retire_i);

  assign fetch_pc_o = pc_q;
  assign flush_req_o = accept && is_fence;
  assign spec_start_o = accept && is_branch && btb_valid_i && !spec_q;
  assign spec_target_o = btb_target_i;
  assign fallthrough_pc_o = pc_q + 32'd4;
  assign spec_active_o = spec_q || (state_q == ifu_pkg::FLUSH);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ifu_pkg::FETCH;
      pc_q <= ifu_pkg::PC_INIT;
      spec_q <= 1'b0;
    end else if (spec_bad_i) begin
      state_q <= ifu_pkg::FLUSH;
      spec_q <= 1'b0;
    end else begin
      if (spec_good_i) begin
        spec_q <= 1'b0;
      end
      case (state_q)
        ifu_pkg::FETCH: begin
          if (accept) begin
            if (is_fence || is_load) begin
              state_q <= ifu_pkg::HAZARD;
            end else if (spec_start_o) begin
              pc_q <= btb_target_i;
              spec_q <= 1'b1;
            end else if (is_branch) begin
              state_q <= ifu_pkg::HAZARD;
            end else begin
              pc_q <= pc_q + 32'd4;
            end
          end
        end
        ifu_pkg::HAZARD: begin
          // An open guess is resolved before the stalled instruction
          if (resolved && !spec_q) begin
            state_q <= ifu_pkg::FETCH;
            pc_q <= pc_change_i ? npc_i : pc_q + 32'd4;
          end
        end
        ifu_pkg::FLUSH: begin
          if (cache_idle_i) begin
            state_q <= ifu_pkg::FETCH;
            pc_q <= redirect_pc_i;
          end
        end
        default: begin
          state_q <= ifu_pkg::FETCH;
        end
      endcase
    end
  end

endmodule

/* source/ifu_top.sv */
`timescale 1ns/1ps

module ifu_top (
  input  logic                     clk,
  input  logic                     rst,
  output logic [ifu_pkg::XLEN-1:0] ifu_araddr_o,
  output logic                     ifu_arvalid_o,
  output logic                     ifu_required_o,
  input  logic [ifu_pkg::XLEN-1:0] ifu_rdata_i,
  input  logic                     ifu_rvalid_i,
  output logic [ifu_pkg::XLEN-1:0] inst_o,
  output logic [ifu_pkg::XLEN-1:0] pc_o,
  output logic                     valid_o,
  input  logic                     next_ready_i,
  input  logic                     prev_valid_i,
  input  logic                     pc_change_i,
  input  logic [ifu_pkg::XLEN-1:0] npc_i,
  input  logic                     pc_retire_i,
  input  logic [ifu_pkg::XLEN-1:0] pc_i,
  output logic                     speculation_o,
  output logic                     good_speculation_o,
  output logic                     bad_speculation_o
);

  logic                     hit;
  logic                     cache_idle;
  logic                     flush_req;
  logic                     btb_valid;
  logic [ifu_pkg::XLEN-1:0] btb_target;
  logic                     spec_good;
  logic                     spec_bad;
  logic [ifu_pkg::XLEN-1:0] redirect_pc;
  logic                     spec_start;
  logic [ifu_pkg::XLEN-1:0] spec_target;
  logic [ifu_pkg::XLEN-1:0] fallthrough_pc;
  logic                     spec_active;

  ifu_fetch_fsm i_fetch_fsm (
    .clk(clk), .rst(rst),
    .hit_i(hit), .inst_i(inst_o), .cache_idle_i(cache_idle),
    .next_ready_i(next_ready_i), .prev_valid_i(prev_valid_i),
    .pc_change_i(pc_change_i), .npc_i(npc_i),
    .pc_retire_i(pc_retire_i), .pc_i(pc_i),
    .btb_valid_i(btb_valid), .btb_target_i(btb_target),
    .spec_good_i(spec_good), .spec_bad_i(spec_bad), .redirect_pc_i(redirect_pc),
    .fetch_pc_o(pc_o), .valid_o(valid_o), .flush_req_o(flush_req),
    .spec_start_o(spec_start), .spec_target_o(spec_target),
    .fallthrough_pc_o(fallthrough_pc), .spec_active_o(spec_active)
  );

  ifu_l1i_cache i_l1i_cache (
    .clk(clk), .rst(rst),
    .pc_i(pc_o), .flush_i(flush_req),
    .rdata_i(ifu_rdata_i), .rvalid_i(ifu_rvalid_i),
    .hit_o(hit), .inst_o(inst_o), .idle_o(cache_idle),
    .araddr_o(ifu_araddr_o), .arvalid_o(ifu_arvalid_o), .required_o(ifu_required_o)
  );

  ifu_spec_tracker i_spec_tracker (
    .clk(clk), .rst(rst),
    .prev_valid_i(prev_valid_i),
    .pc_change_i(pc_change_i), .npc_i(npc_i),
    .pc_retire_i(pc_retire_i), .pc_i(pc_i),
    .spec_start_i(spec_start), .spec_target_i(spec_target),
    .fallthrough_pc_i(fallthrough_pc), .spec_active_i(spec_active),
    .btb_valid_o(btb_valid), .btb_target_o(btb_target),
    .spec_good_o(spec_good), .spec_bad_o(spec_bad), .redirect_pc_o(redirect_pc),
    .speculation_o(speculation_o), .good_speculation_o(good_speculation_o),
    .bad_speculation_o(bad_speculation_o)
  );

endmodule

/* verif/ifu_assertions.sv */
`timescale 1ns/1ps

module ifu_assertions (
  input logic clk,
  input logic rst,
  input logic arvalid_i,
  input logic rvalid_i,
  input logic valid_i,
  input logic good_spec_i,
  input logic bad_spec_i
);

  int fail_count = 0;

  // A read request stays up until its data pulse arrives
  a_request_held: assert property (@(posedge clk) disable iff (rst)
    arvalid_i && !rvalid_i |=> arvalid_i)
    else begin
      fail_count++;
      $error("bus request withdrawn before its data returned");
    end

  a_no_valid_in_flush: assert property (@(posedge clk) disable iff (rst)
    bad_spec_i |-> !valid_i)
    else begin
      fail_count++;
      $error("instruction offered to decode during a flush");
    end

  // A good resolution closes the guess and no status pulse follows it
  a_good_bad_apart: assert property (@(posedge clk) disable iff (rst)
    good_spec_i |-> !bad_spec_i ##1 (!good_spec_i && !bad_spec_i))
    else begin
      fail_count++;
      $error("good and bad speculation reported together or repeated");
    end

endmodule

/* verif/ifu_tb.sv */
`timescale 1ns/1ps

module ifu_tb;

  logic                     clk;
  logic                     rst;
  logic [ifu_pkg::XLEN-1:0] araddr;
  logic                     arvalid;
  logic                     required;
  logic [ifu_pkg::XLEN-1:0] rdata;
  logic                     rvalid;
  logic [ifu_pkg::XLEN-1:0] inst;
  logic [ifu_pkg::XLEN-1:0] pc;
  logic                     valid;
  logic                     next_ready;
  logic                     prev_valid;
  logic                     pc_change;
  logic [ifu_pkg::XLEN-1:0] npc;
  logic                     pc_retire;
  logic [ifu_pkg::XLEN-1:0] retire_pc;
  logic                     speculation;
  logic                     good_spec;
  logic                     bad_spec;

  // Words 0 to 63 hold the memory image and the commands start at word 64
  logic [ifu_pkg::XLEN-1:0] stim [512];
  int latency = 1;
  int wait_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;
  int checks = 0;
  int errors = 0;
  logic req_seen = 1'b0;
  logic arv_seen = 1'b0;

  ifu_top i_dut (
    .clk(clk), .rst(rst),
    .ifu_araddr_o(araddr), .ifu_arvalid_o(arvalid), .ifu_required_o(required),
    .ifu_rdata_i(rdata), .ifu_rvalid_i(rvalid),
    .inst_o(inst), .pc_o(pc), .valid_o(valid), .next_ready_i(next_ready),
    .prev_valid_i(prev_valid), .pc_change_i(pc_change), .npc_i(npc),
    .pc_retire_i(pc_retire), .pc_i(retire_pc),
    .speculation_o(speculation), .good_speculation_o(good_spec),
    .bad_speculation_o(bad_spec)
  );

  bind ifu_top ifu_assertions i_assertions (
    .clk(clk), .rst(rst), .arvalid_i(ifu_arvalid_o), .rvalid_i(ifu_rvalid_i),
    .valid_i(valid_o), .good_spec_i(good_speculation_o), .bad_spec_i(bad_speculation_o)
  );

  always #20 clk = ~clk;

  // **************************************************
  // Memory model and bus activity monitor
  // **************************************************
  always begin
    @(negedge clk);
    if (arvalid && !rvalid) begin
      wait_count++;
    end
    if (wait_count >= latency) begin
      // The image covers 64 words from the reset address
      check_word("ifu_araddr_o", araddr & ~32'h0000_00fc, ifu_pkg::PC_INIT);
      rdata <= stim[araddr[7:2]];
      @(posedge clk);
      #2;
      rvalid = 1'b1;
      @(posedge clk);
      #2;
      rvalid = 1'b0;
      wait_count = 0;
    end
  end

  always @(negedge clk) begin
    if (required) req_seen = 1'b1;
    if (arvalid) arv_seen = 1'b1;
  end

  initial begin : watchdog
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // **************************************************
  // Compare tasks and back end actions
  // **************************************************
  task automatic check_word(input string name, input logic [ifu_pkg::XLEN-1:0] actual,
                            input logic [ifu_pkg::XLEN-1:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
    end
  endtask

  // Decode is ready until one instruction has been taken
  task automatic take_instruction(input logic [ifu_pkg::XLEN-1:0] exp_pc,
                                  input logic [ifu_pkg::XLEN-1:0] exp_inst,
                                  input logic exp_spec);
    next_ready = 1'b1;
    @(negedge clk);
    while (valid !== 1'b1) begin
      @(negedge clk);
    end
    check_word("pc_o", pc, exp_pc);
    check_word("inst_o", inst, exp_inst);
    check_bit("speculation_o", speculation, exp_spec);
    @(posedge clk);
    #2;
    next_ready = 1'b0;
  endtask

  task automatic resolve(input logic by_redirect, input logic [ifu_pkg::XLEN-1:0] value,
                         input logic exp_good, input logic exp_bad);
    prev_valid = 1'b1;
    pc_change = by_redirect;
    pc_retire = !by_redirect;
    npc = value;
    retire_pc = value;
    @(negedge clk);
    check_bit("good_speculation_o", good_spec, exp_good);
    check_bit("bad_speculation_o", bad_spec, exp_bad);
    @(posedge clk);
    #2;
    prev_valid = 1'b0;
    pc_change = 1'b0;
    pc_retire = 1'b0;
  endtask

  task automatic hold_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_bit("valid_o", valid, 1'b0);
      @(posedge clk);
    end
    #2;
  endtask

  task automatic check_refill(input logic expected);
    check_bit("ifu_required_o seen", req_seen, expected);
    check_bit("ifu_arvalid_o seen", arv_seen, expected);
    req_seen = 1'b0;
    arv_seen = 1'b0;
  endtask

  initial begin : main
    int p;
    int expects;
    int tests;
    int test_errors;
    logic [ifu_pkg::XLEN-1:0] op;
    clk = 1'b0;
    rst = 1'b1;
    rdata = '0;
    rvalid = 1'b0;
    next_ready = 1'b0;
    prev_valid = 1'b0;
    pc_change = 1'b0;
    npc = '0;
    pc_retire = 1'b0;
    retire_pc = '0;
    $readmemh("verif/ifu_stimulus.txt", stim);
    expects = 0;
    for (p = 64; p < 512 && stim[p] != '0; p += 4) begin
      if (stim[p] == 2) expects++;
    end
    cycle_limit = 64 * expects + 200;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    tests = 0;
    test_errors = 0;
    p = 64;
    while (p < 512 && stim[p] != '0) begin
      op = stim[p];
      case (op)
        1: latency = int'(stim[p+1]);
        2: take_instruction(stim[p+1], stim[p+2], stim[p+3][0]);
        3: resolve(1'b1, stim[p+1], stim[p+2][0], stim[p+3][0]);
        4: resolve(1'b0, stim[p+1], stim[p+2][0], stim[p+3][0]);
        5: hold_idle(int'(stim[p+1]));
        6: check_refill(stim[p+1][0]);
        7: begin
          tests++;
          $display("test %0d finished with %0d errors", tests, errors - test_errors);
          test_errors = errors;
        end
        default: begin
          errors++;
          $display("Stimulus file holds an unknown command %h at word %0d", op, p);
          break;
        end
      endcase
      p += 4;
    end
    errors += i_dut.i_assertions.fail_count;
    if (tests == 0) begin
      errors++;
      $display("No tests were read from the stimulus file");
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verif/ifu_stimulus.txt */
// Words 0 to 63: memory image from 0x80000000, one instruction word each
// From word 0x40: code, arg1, arg2, arg3 per line
// Codes: 1 latency, 2 expect pc inst speculation_o, 3 redirect npc good bad,
// 4 retire pc good bad, 5 idle cycles, 6 refill seen, 7 end of test, 0 end of list
@0
00100093 00200093 00300093 0000006f
00002103 00400093 00000063 00500093
00600093 0000100f 00700093 00800093
00000013 00000013 00000013 00000013
@40
// Test 1: fetch after reset up to a branch with an empty target register
1 1 0 0
2 80000000 00100093 0
2 80000004 00200093 0
2 80000008 00300093 0
2 8000000c 0000006f 0
6 1 0 0
7 0 0 0
// Test 2: redirect resumes at npc, the re-run hits, the branch then speculates
5 3 0 0
3 80000000 0 0
2 80000000 00100093 0
2 80000004 00200093 0
2 80000008 00300093 0
6 0 0 0
2 8000000c 0000006f 0
7 0 0 0
// Test 3: matching redirect
2 80000000 00100093 1
3 80000000 1 0
2 80000004 00200093 0
2 80000008 00300093 0
2 8000000c 0000006f 0
7 0 0 0
// Test 4: mismatching redirect
1 4 0 0
2 80000000 00100093 1
3 80000010 0 1
2 80000010 00002103 0
7 0 0 0
// Test 5: load stall released by a retire
5 3 0 0
4 80000010 0 0
2 80000014 00400093 0
2 80000018 00000063 0
7 0 0 0
// Test 6: load held while speculating, mismatching retire, fence.i
5 3 0 0
4 80000018 0 1
2 8000001c 00500093 0
2 80000020 00600093 0
2 80000024 0000100f 0
6 1 0 0
7 0 0 0
// Test 7: a line cached before fence.i is fetched again over the bus
5 14 0 0
6 1 0 0
3 8000001c 0 0
2 8000001c 00500093 0
6 1 0 0
2 80000020 00600093 0
6 0 0 0
7 0 0 0
0 0 0 0

/* ifu.f */
source/ifu_pkg.sv
source/ifu_refill_counter.sv
source/ifu_l1i_cache.sv
source/ifu_spec_tracker.sv
source/ifu_fetch_fsm.sv
source/ifu_top.sv
verif/ifu_assertions.sv
verif/ifu_tb.sv

/* Bender.yml */
package:
  name: ifu

sources:
  - source/ifu_pkg.sv
  - source/ifu_refill_counter.sv
  - source/ifu_l1i_cache.sv
  - source/ifu_spec_tracker.sv
  - source/ifu_fetch_fsm.sv
  - source/ifu_top.sv
  - target: test
    files:
      - verif/ifu_assertions.sv
      - verif/ifu_tb.sv
